// ==== logic/rst_seq_consts.svh ====
//----------------------------
// counter limits and widths of the reset sequencer
// include wherever the window lengths or the BIST word size are needed
//----------------------------

`ifndef RST_SEQ_CONSTS_SVH
`define RST_SEQ_CONSTS_SVH

// last count of the eFuse read window, 8000 cycles at 200 MHz
`define RST_SEQ_EFC_CNT 8000

// last count of the DRAM self-refresh hold in a_grst
`define RST_SEQ_DRAM_GRST_CNT 1600

// width of both window counters, large enough for the eFuse window
`define RST_SEQ_CNT_W 13

// serial BIST control word shifted in after the type bit
`define RST_SEQ_BIST_CTRL_W 6

`endif

// ==== logic/rst_seq_pkg.sv ====
//----------------------------
// types shared by the reset sequencer blocks
// import with rst_seq_pkg::* in the module header
//----------------------------

`default_nettype none

`include "rst_seq_consts.svh"

package rst_seq_pkg;

  // sequencer states, power-on path first, then the warm reset path
  typedef enum logic [3:0] {
    wait_lock,
    start_clk,
    en_clk,
    wait_j_rst,
    de_dllrst,
    de_grst,
    efc_rd,
    wait_bist,
    idle,
    a_grst,
    a_dgrst,
    dis_clk,
    chng_frq,
    wait_rst
  } seq_state_t;

  typedef logic [`RST_SEQ_CNT_W-1:0] seq_cnt_t;

  typedef logic [`RST_SEQ_BIST_CTRL_W-1:0] bist_ctrl_t;

  // {freq_change, power_on, warm}
  typedef logic [2:0] rst_stat_t;

endpackage

`default_nettype wire

// ==== logic/rst_input_sync.sv ====
//----------------------------
// brings the reset, BIST and handshake pins into jbus_clk
// and frames the release edge of the system reset pin
//----------------------------

`default_nettype none

module rst_input_sync (
  input  logic jbus_clk,
  input  logic arst_n,
  input  logic j_rst_n,
  input  logic do_bist,
  input  logic clkctrl_done,
  input  logic dll_rst_done,
  input  logic grst_released_n,
  output logic j_rst_n_sync,
  output logic do_bist_sync,
  output logic clkctrl_done_sync,
  output logic dll_rst_done_sync,
  output logic grst_released_sync,
  output logic j_rel_pulse,
  output logic j_rel_pulse_dly
);

  // all five pins share one two-stage chain so they keep the same latency
  logic [4:0] sync_meta;
  logic [4:0] sync_q;
  logic       j_rst_n_sync_d;

  //----------------------------
  // two-flop synchronizers
  //----------------------------
  always_ff @(posedge jbus_clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      sync_meta <= '0;
      sync_q    <= '0;
    end
    else
    begin
      sync_meta <= {j_rst_n, do_bist, clkctrl_done, dll_rst_done, grst_released_n};
      sync_q    <= sync_meta;
    end
  end

  assign {j_rst_n_sync, do_bist_sync, clkctrl_done_sync,
          dll_rst_done_sync, grst_released_sync} = sync_q;

  //----------------------------
  // release edge of j_rst_n
  //----------------------------
  always_ff @(posedge jbus_clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      j_rst_n_sync_d  <= 1'b0;
      j_rel_pulse     <= 1'b0;
      j_rel_pulse_dly <= 1'b0;
    end
    else
    begin
      j_rst_n_sync_d  <= j_rst_n_sync;
      // one cycle after the synced pin first reads high
      j_rel_pulse     <= j_rst_n_sync & ~j_rst_n_sync_d;
      j_rel_pulse_dly <= j_rel_pulse;
    end
  end

endmodule

`default_nettype wire

// ==== logic/bist_cfg_capture.sv ====
//----------------------------
// captures the serial BIST setup word from do_bist
// request bit, type bit, then the control word MSB first
//----------------------------

`default_nettype none

`include "rst_seq_consts.svh"

module bist_cfg_capture
  import rst_seq_pkg::*;
(
  input  logic       jbus_clk,
  input  logic       arst_n,
  input  logic       do_bist_sync,
  input  logic       j_rel_pulse,
  input  logic       j_rel_pulse_dly,
  output logic       bist_req,
  output logic       bist_type,
  output bist_ctrl_t bist_ctrl
);

  localparam int CNT_W = $clog2(`RST_SEQ_BIST_CTRL_W + 1);
  localparam logic [CNT_W-1:0] WORD_LEN = CNT_W'(`RST_SEQ_BIST_CTRL_W);

  // one extra stage lines the data up with the registered release pulse
  logic             do_bist_d;
  logic [CNT_W-1:0] bit_cnt;

  always_ff @(posedge jbus_clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      do_bist_d <= 1'b0;
      bist_req  <= 1'b0;
      bist_type <= 1'b0;
    end
    else
    begin
      do_bist_d <= do_bist_sync;
      if (j_rel_pulse)
        bist_req <= do_bist_d;
      if (j_rel_pulse_dly)
        bist_type <= do_bist_d;
    end
  end

  //----------------------------
  // control word bit counter
  //----------------------------
  // loaded with the word length, counts down to zero and then rests
  always_ff @(posedge jbus_clk or negedge arst_n)
  begin
    if (!arst_n)
      bit_cnt <= '0;
    else if (j_rel_pulse_dly)
      bit_cnt <= WORD_LEN;
    else if (bit_cnt != '0)
      bit_cnt <= bit_cnt - 1'b1;
  end

  // count n enables ctrl[n-1], so the first bit lands in the MSB
  always_ff @(posedge jbus_clk or negedge arst_n)
  begin
    if (!arst_n)
      bist_ctrl <= '0;
    else
    begin
      for (int i = 0; i < `RST_SEQ_BIST_CTRL_W; i++)
      begin
        if (bit_cnt == CNT_W'(i + 1))
          bist_ctrl[i] <= do_bist_d;
      end
    end
  end

endmodule

`default_nettype wire

// ==== logic/rst_seq_fsm.sv ====
//----------------------------
// reset sequencing state machine with the eFuse and DRAM windows
// next_state is forced to wait_lock whenever the PLL is unlocked
//----------------------------

`default_nettype none

`include "rst_seq_consts.svh"

module rst_seq_fsm
  import rst_seq_pkg::*;
(
  input  logic       jbus_clk,
  input  logic       arst_n,
  input  logic       pll_locked,
  input  logic       j_rst_n_sync,
  input  logic       clkctrl_done_sync,
  input  logic       dll_rst_done_sync,
  input  logic       grst_released_sync,
  input  logic       bist_req,
  input  logic       bist_done,
  input  logic       selfrsh_arm,
  input  logic       freq_change,
  input  logic       power_on,
  output seq_state_t state,
  output seq_state_t next_state
);

  seq_state_t nxt_raw;
  seq_cnt_t   efc_cnt;
  seq_cnt_t   dram_cnt;
  logic       efc_done;
  logic       dram_done;

  // window counter step, cleared on entry and counting while in the state
  function automatic seq_cnt_t win_cnt_step(seq_cnt_t cnt, logic entering, logic in_state);
    seq_cnt_t step;
    step = cnt;
    if (entering)
      step = '0;
    else if (in_state)
      step = cnt + seq_cnt_t'(1);
    return step;
  endfunction

  //----------------------------
  // window counters
  //----------------------------
  always_ff @(posedge jbus_clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      efc_cnt  <= '0;
      dram_cnt <= '0;
    end
    else
    begin
      efc_cnt  <= win_cnt_step(efc_cnt, (next_state == efc_rd) && (state != efc_rd),
                               state == efc_rd);
      dram_cnt <= win_cnt_step(dram_cnt, (next_state == a_grst) && (state != a_grst),
                               state == a_grst);
    end
  end

  assign efc_done  = (efc_cnt == seq_cnt_t'(`RST_SEQ_EFC_CNT));
  assign dram_done = (dram_cnt == seq_cnt_t'(`RST_SEQ_DRAM_GRST_CNT));

  //----------------------------
  // next state
  //----------------------------
  always_comb
  begin
    nxt_raw = state;
    case (state)
      wait_lock:
        nxt_raw = start_clk;
      // clocks are started by the registered start_clk, then enabled
      start_clk:
        nxt_raw = en_clk;
      en_clk:
        if (clkctrl_done_sync)
          nxt_raw = wait_j_rst;
      wait_j_rst:
        if (j_rst_n_sync)
          nxt_raw = de_dllrst;
      de_dllrst:
        if (dll_rst_done_sync)
          nxt_raw = de_grst;
      de_grst:
        if (grst_released_sync)
        begin
          if (power_on)
            nxt_raw = efc_rd;
          else if (bist_req)
            nxt_raw = wait_bist;
          else
            nxt_raw = idle;
        end
      efc_rd:
        if (efc_done)
          nxt_raw = bist_req ? wait_bist : idle;
      wait_bist:
        if (bist_done)
          nxt_raw = idle;
      // a new assertion of the reset pin starts a warm reset
      idle:
        if (!j_rst_n_sync)
          nxt_raw = a_grst;
      // hold grst for the self-refresh window only when it is armed
      a_grst:
        if (!selfrsh_arm)
          nxt_raw = dis_clk;
        else if (dram_done)
          nxt_raw = a_dgrst;
      a_dgrst:
        nxt_raw = dis_clk;
      dis_clk:
        if (clkctrl_done_sync)
          nxt_raw = freq_change ? chng_frq : wait_rst;
      chng_frq:
        nxt_raw = wait_rst;
      // the PLL relocks with the new ratio, so wait for it to drop first
      // the lock gate on next_state takes the FSM back to wait_lock
      wait_rst:
        nxt_raw = wait_rst;
      default:
        nxt_raw = wait_lock;
    endcase
  end

  assign next_state = pll_locked ? nxt_raw : wait_lock;

  always_ff @(posedge jbus_clk or negedge arst_n)
  begin
    if (!arst_n)
      state <= wait_lock;
    else
      state <= next_state;
  end

endmodule

`default_nettype wire

// ==== logic/rst_seq_outputs.sv ====
//----------------------------
// registered control outputs of the reset sequencer
// also keeps the frequency-change latch, reset status and self-refresh
//----------------------------

`default_nettype none

module rst_seq_outputs
  import rst_seq_pkg::*;
(
  input  logic       jbus_clk,
  input  logic       arst_n,
  input  logic       pll_locked,
  input  logic       freq_chng_pending,
  input  logic       selfrsh_arm,
  input  logic       bist_req,
  input  seq_state_t state,
  input  seq_state_t next_state,
  output logic       start_clk,
  output logic       en_clk,
  output logic       dis_clk,
  output logic       dll_rst_n,
  output logic       de_grst,
  output logic       a_grst,
  output logic       dram_a_grst,
  output logic       efc_read_start,
  output logic       wake_thr,
  output logic       bist_start,
  output logic       update_shadow,
  output logic       idle,
  output logic       self_refresh,
  output logic       freq_change,
  output logic       power_on,
  output logic       stat_wr,
  output rst_stat_t  reset_stat
);

  logic ns_run;
  logic ns_dll_on;
  logic ns_dram_grst;
  logic to_idle;
  logic to_bist;
  logic warm_start;
  logic in_a_grst;
  logic freq_stat;
  logic warm_stat;

  // state literals are package qualified, several share a name with a port
  assign ns_run = (next_state != rst_seq_pkg::wait_lock) &&
                  (next_state != rst_seq_pkg::wait_rst);
  assign ns_dll_on = next_state inside {rst_seq_pkg::de_dllrst, rst_seq_pkg::de_grst,
                                        rst_seq_pkg::efc_rd, rst_seq_pkg::wait_bist,
                                        rst_seq_pkg::idle, rst_seq_pkg::a_grst};
  // without self-refresh, DRAM takes grst together with the core
  assign ns_dram_grst = (next_state == rst_seq_pkg::a_dgrst) ||
                        (next_state == rst_seq_pkg::dis_clk) ||
                        ((next_state == rst_seq_pkg::a_grst) && !selfrsh_arm);
  assign to_idle = (next_state == rst_seq_pkg::idle) &&
                   (state inside {rst_seq_pkg::de_grst, rst_seq_pkg::efc_rd,
                                  rst_seq_pkg::wait_bist});
  assign to_bist = (next_state == rst_seq_pkg::wait_bist) &&
                   (state inside {rst_seq_pkg::de_grst, rst_seq_pkg::efc_rd});
  assign warm_start = (state == rst_seq_pkg::idle) && (next_state == rst_seq_pkg::a_grst);
  assign in_a_grst  = (state == rst_seq_pkg::a_grst) && pll_locked;

  //----------------------------
  // state-decoded controls
  //----------------------------
  always_ff @(posedge jbus_clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      start_clk      <= 1'b0;
      en_clk         <= 1'b0;
      dis_clk        <= 1'b0;
      dll_rst_n      <= 1'b0;
      de_grst        <= 1'b0;
      a_grst         <= 1'b0;
      dram_a_grst    <= 1'b0;
      efc_read_start <= 1'b0;
      wake_thr       <= 1'b0;
      stat_wr        <= 1'b0;
      bist_start     <= 1'b0;
      update_shadow  <= 1'b0;
      idle           <= 1'b0;
    end
    else
    begin
      start_clk      <= ns_run & pll_locked;
      en_clk         <= (next_state == rst_seq_pkg::en_clk) & pll_locked;
      dis_clk        <= (next_state == rst_seq_pkg::dis_clk) & pll_locked;
      dll_rst_n      <= ns_dll_on & pll_locked;
      de_grst        <= (next_state == rst_seq_pkg::de_grst) & pll_locked;
      a_grst         <= (next_state == rst_seq_pkg::a_grst) & pll_locked;
      dram_a_grst    <= ns_dram_grst & pll_locked;
      efc_read_start <= (state == rst_seq_pkg::de_grst) &
                        (next_state == rst_seq_pkg::efc_rd) & pll_locked;
      wake_thr       <= to_idle & pll_locked;
      stat_wr        <= to_idle & pll_locked;
      bist_start     <= to_bist & bist_req & pll_locked;
      update_shadow  <= (next_state == rst_seq_pkg::chng_frq) & pll_locked;
      idle           <= ((next_state == rst_seq_pkg::idle) |
                         (next_state == rst_seq_pkg::wait_rst)) & pll_locked;
    end
  end

  //----------------------------
  // frequency change and status
  //----------------------------
  // power_on comes out of reset set, warm and freq_change are set in a_grst
  always_ff @(posedge jbus_clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      freq_change <= 1'b0;
      freq_stat   <= 1'b0;
      warm_stat   <= 1'b0;
      power_on    <= 1'b1;
    end
    else
    begin
      // sampled every idle cycle, held through the warm reset
      if (state == rst_seq_pkg::idle)
        freq_change <= freq_chng_pending & pll_locked;
      if (in_a_grst && freq_change)
        freq_stat <= 1'b1;
      else if (stat_wr)
        freq_stat <= 1'b0;
      if (in_a_grst && !freq_change)
        warm_stat <= 1'b1;
      else if (stat_wr)
        warm_stat <= 1'b0;
      if (stat_wr)
        power_on <= 1'b0;
    end
  end

  assign reset_stat = {freq_stat, power_on, warm_stat};

  // DRAM stays in self-refresh across the relock, until grst is released
  always_ff @(posedge jbus_clk or negedge arst_n)
  begin
    if (!arst_n)
      self_refresh <= 1'b0;
    else if (warm_start && selfrsh_arm && pll_locked)
      self_refresh <= 1'b1;
    else if ((state == rst_seq_pkg::de_grst) && (next_state != rst_seq_pkg::de_grst))
      self_refresh <= 1'b0;
  end

endmodule

`default_nettype wire

// ==== logic/rst_seq_top.sv ====
//----------------------------
// top of the reset sequencer, all logic on jbus_clk
// wires the pin synchronizers, BIST capture, FSM and output block
//----------------------------

`default_nettype none

module rst_seq_top
  import rst_seq_pkg::*;
(
  input  logic       jbus_clk,
  input  logic       arst_n,
  input  logic       pll_locked,
  input  logic       j_rst_n,
  input  logic       do_bist,
  input  logic       clkctrl_done,
  input  logic       dll_rst_done,
  input  logic       grst_released_n,
  input  logic       bist_done,
  input  logic       selfrsh_arm,
  input  logic       freq_chng_pending,
  output logic       start_clk,
  output logic       en_clk,
  output logic       dis_clk,
  output logic       dll_rst_n,
  output logic       de_grst,
  output logic       a_grst,
  output logic       dram_a_grst,
  output logic       efc_read_start,
  output logic       wake_thr,
  output logic       bist_start,
  output logic       update_shadow,
  output logic       idle,
  output logic       self_refresh,
  output logic       stat_wr,
  output rst_stat_t  reset_stat,
  output logic       bist_type,
  output bist_ctrl_t bist_ctrl
);

  logic       j_rst_n_sync;
  logic       do_bist_sync;
  logic       clkctrl_done_sync;
  logic       dll_rst_done_sync;
  logic       grst_released_sync;
  logic       j_rel_pulse;
  logic       j_rel_pulse_dly;
  logic       bist_req;
  logic       freq_change;
  logic       power_on;
  seq_state_t state;
  seq_state_t next_state;

  // port and net names match across the blocks
  rst_input_sync u_input_sync (.*);

  bist_cfg_capture u_bist_cfg (.*);

  rst_seq_fsm u_fsm (.*);

  rst_seq_outputs u_outputs (.*);

endmodule

`default_nettype wire

// ==== dv/rst_seq_tb.sv ====
//----------------------------
// testbench for the reset sequencer top level
// random responders answer the clock, DLL and grst handshakes
// runs a power-on, a self-refresh warm reset and a frequency-change reset
//----------------------------

`default_nettype none

`include "rst_seq_consts.svh"

module rst_seq_tb
  import rst_seq_pkg::*;
;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int MAX_DLY = 20;
  // three sequences, each with both windows and about a dozen responder waits
  localparam int CYCLE_LIMIT = 3 * (`RST_SEQ_EFC_CNT + `RST_SEQ_DRAM_GRST_CNT + 3 +
                                    12 * (MAX_DLY + 4) + 100);

  logic       jbus_clk = 1'b0;
  logic       arst_n;
  logic       pll_locked;
  logic       j_rst_n;
  logic       do_bist;
  logic       clkctrl_done = 1'b0;
  logic       dll_rst_done = 1'b0;
  logic       grst_released_n = 1'b0;
  logic       bist_done = 1'b0;
  logic       selfrsh_arm;
  logic       freq_chng_pending;
  logic       start_clk, en_clk, dis_clk, dll_rst_n, de_grst, a_grst, dram_a_grst;
  logic       efc_read_start, wake_thr, bist_start, update_shadow, idle;
  logic       self_refresh, stat_wr, bist_type;
  rst_stat_t  reset_stat;
  bist_ctrl_t bist_ctrl;

  // model state and event timestamps
  rst_stat_t exp_stat;
  int cycle = 0;
  int t_start, t_en, t_dll, t_dg, t_efc, t_wake, t_dis, t_upd, t_bist_done;
  int n_upd = 0;
  int n_bist = 0;
  int agrst_len = 0;
  logic zero_chk = 1'b0;
  logic sc_q, en_q, dll_q, dg_q, efc_q, wk_q, dis_q, upd_q, ag_q, bs_q;

  rst_seq_top dut0 (.*);

  always #2 jbus_clk = ~jbus_clk;

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Finished with errors");
    $fatal(1);
  endtask

  task automatic expect_hex(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
    assert (got == exp)
    else
      fail_run($sformatf("MISMATCH %s got 0x%0h exp 0x%0h", name, got, exp));
  endtask

  task automatic expect_true(input logic cond, input string what);
    assert (cond)
    else
      fail_run(what);
  endtask

  task automatic check_controls_low();
    expect_hex("start_clk", 32'(start_clk), 0);
    expect_hex("en_clk", 32'(en_clk), 0);
    expect_hex("dis_clk", 32'(dis_clk), 0);
    expect_hex("dll_rst_n", 32'(dll_rst_n), 0);
    expect_hex("de_grst", 32'(de_grst), 0);
    expect_hex("a_grst", 32'(a_grst), 0);
    expect_hex("dram_a_grst", 32'(dram_a_grst), 0);
    expect_hex("efc_read_start", 32'(efc_read_start), 0);
    expect_hex("wake_thr", 32'(wake_thr), 0);
    expect_hex("bist_start", 32'(bist_start), 0);
    expect_hex("update_shadow", 32'(update_shadow), 0);
    expect_hex("idle", 32'(idle), 0);
    expect_hex("stat_wr", 32'(stat_wr), 0);
  endtask

  // releases the reset pin once the clocks are up and shifts the setup word
  task automatic release_with_word(input logic [7:0] pat);
    while (!en_clk)
      @(negedge jbus_clk);
    while (en_clk)
      @(negedge jbus_clk);
    j_rst_n = 1'b1;
    for (int k = 0; k < 8; k++)
    begin
      do_bist = pat[k];
      @(negedge jbus_clk);
    end
    do_bist = 1'b0;
  endtask

  // waits for wake_thr, then one more cycle so the monitor timestamps settle
  task automatic wait_wake_and_check_word(input logic [7:0] pat);
    bist_ctrl_t exp_ctrl;
    for (int i = 0; i < `RST_SEQ_BIST_CTRL_W; i++)
      exp_ctrl[`RST_SEQ_BIST_CTRL_W-1-i] = pat[2+i];
    while (!wake_thr)
      @(negedge jbus_clk);
    @(negedge jbus_clk);
    expect_hex("idle", 32'(idle), 1);
    expect_hex("bist_type", 32'(bist_type), 32'(pat[1]));
    expect_hex("bist_ctrl", 32'(bist_ctrl), 32'(exp_ctrl));
  endtask

  task automatic warm_reset();
    j_rst_n = 1'b0;
    while (!a_grst)
      @(negedge jbus_clk);
    if (selfrsh_arm)
    begin
      expect_hex("self_refresh", 32'(self_refresh), 1);
      expect_hex("dram_a_grst", 32'(dram_a_grst), 0);
    end
    freq_chng_pending = 1'b0;
    while (!dis_clk)
      @(negedge jbus_clk);
    if (selfrsh_arm)
    begin
      expect_hex("a_grst_len", 32'(agrst_len), 32'(`RST_SEQ_DRAM_GRST_CNT + 1));
      expect_hex("dram_a_grst", 32'(dram_a_grst), 1);
    end
    while (dis_clk)
      @(negedge jbus_clk);
    // sequencer now waits for the PLL to drop lock
    repeat (3) @(negedge jbus_clk);
    pll_locked = 1'b0;
    repeat (3) @(negedge jbus_clk);
    check_controls_low();
    pll_locked = 1'b1;
  endtask

  //----------------------------
  // responders
  //----------------------------
  int cc_cnt, dll_cnt, gr_cnt, bd_cnt;

  always @(negedge jbus_clk)
  begin
    if (!arst_n)
    begin
      clkctrl_done = 1'b0;
      dll_rst_done = 1'b0;
      grst_released_n = 1'b0;
      bist_done = 1'b0;
      cc_cnt = 0;
      dll_cnt = 0;
      gr_cnt = 0;
      bd_cnt = 0;
    end
    else
    begin
      clkctrl_done = 1'b0;
      if ((en_clk && !en_q) || (dis_clk && !dis_q))
        cc_cnt = $urandom_range(MAX_DLY, 1);
      else if (cc_cnt > 0)
      begin
        cc_cnt--;
        if (cc_cnt == 0)
          clkctrl_done = 1'b1;
      end
      if (!dll_rst_n)
      begin
        dll_rst_done = 1'b0;
        dll_cnt = 0;
      end
      else if (!dll_q)
        dll_cnt = $urandom_range(MAX_DLY, 1);
      else if (dll_cnt > 0)
      begin
        dll_cnt--;
        if (dll_cnt == 0)
          dll_rst_done = 1'b1;
      end
      if (de_grst && !dg_q)
        gr_cnt = $urandom_range(MAX_DLY, 1);
      else if (gr_cnt > 0)
      begin
        gr_cnt--;
        if (gr_cnt == 0)
          grst_released_n = 1'b1;
      end
      if (!de_grst && dg_q)
        grst_released_n = 1'b0;
      bist_done = 1'b0;
      if (bist_start)
        bd_cnt = $urandom_range(MAX_DLY, 1);
      else if (bd_cnt > 0)
      begin
        bd_cnt--;
        if (bd_cnt == 0)
        begin
          bist_done = 1'b1;
          t_bist_done = cycle;
        end
      end
    end
  end

  //----------------------------
  // monitor
  //----------------------------
  always @(negedge jbus_clk)
  begin
    if (arst_n)
    begin
      cycle++;
      if (cycle > CYCLE_LIMIT)
        fail_run("timeout, the sequencer did not reach the end within the cycle limit");
      if (start_clk && !sc_q) t_start = cycle;
      if (en_clk && !en_q) t_en = cycle;
      if (dll_rst_n && !dll_q) t_dll = cycle;
      if (de_grst && !dg_q) t_dg = cycle;
      if (efc_read_start && !efc_q) t_efc = cycle;
      if (wake_thr && !wk_q) t_wake = cycle;
      if (dis_clk && !dis_q) t_dis = cycle;
      if (update_shadow && !upd_q)
      begin
        t_upd = cycle;
        n_upd++;
      end
      if (bist_start && !bs_q)
        n_bist++;
      if (a_grst)
      begin
        if (!ag_q)
          agrst_len = 0;
        agrst_len++;
      end
      // status must read zero the cycle after the write strobe
      if (zero_chk)
        expect_hex("reset_stat", 32'(reset_stat), 0);
      zero_chk = stat_wr;
      if (stat_wr)
        expect_hex("reset_stat", 32'(reset_stat), 32'(exp_stat));
    end
    // previous-cycle copies, shared with the responders
    {sc_q, en_q, dll_q, dg_q, efc_q} <= {start_clk, en_clk, dll_rst_n, de_grst, efc_read_start};
    {wk_q, dis_q, upd_q, ag_q, bs_q} <= {wake_thr, dis_clk, update_shadow, a_grst, bist_start};
  end

  //----------------------------
  // test sequence
  //----------------------------
  initial
  begin
    logic [7:0] pat;
    int n_bist0;
    int n_upd0;
    void'($urandom(89));
    arst_n = 1'b0;
    pll_locked = 1'b0;
    j_rst_n = 1'b0;
    do_bist = 1'b0;
    selfrsh_arm = 1'b0;
    freq_chng_pending = 1'b0;
    exp_stat = 3'b010;
    repeat (10) @(negedge jbus_clk);
    check_controls_low();
    expect_hex("self_refresh", 32'(self_refresh), 0);
    expect_hex("reset_stat", 32'(reset_stat), 32'(3'b010));
    arst_n = 1'b1;
    repeat (2) @(negedge jbus_clk);
    pll_locked = 1'b1;

    // power-on without a BIST request
    pat = 8'($urandom_range(255, 0)) & 8'hfe;
    release_with_word(pat);
    wait_wake_and_check_word(pat);
    expect_true(t_start < t_en && t_en < t_dll && t_dll < t_dg &&
                t_dg < t_efc && t_efc < t_wake, "power-on outputs came out of order");
    expect_hex("efc_to_wake", 32'(t_wake - t_efc), 32'(`RST_SEQ_EFC_CNT + 1));
    expect_hex("bist_start_count", 32'(n_bist), 0);

    // warm reset with self-refresh and a BIST request
    repeat (5) @(negedge jbus_clk);
    selfrsh_arm = 1'b1;
    exp_stat = 3'b001;
    n_bist0 = n_bist;
    warm_reset();
    pat = 8'($urandom_range(255, 0)) | 8'h01;
    release_with_word(pat);
    wait_wake_and_check_word(pat);
    expect_hex("bist_start_count", 32'(n_bist), 32'(n_bist0 + 1));
    expect_true(t_bist_done > t_dg && t_wake > t_bist_done,
                "wake_thr did not wait for bist_done");
    expect_hex("self_refresh", 32'(self_refresh), 0);

    // warm reset with a pending frequency change
    selfrsh_arm = 1'b0;
    freq_chng_pending = 1'b1;
    exp_stat = 3'b100;
    n_upd0 = n_upd;
    repeat (5) @(negedge jbus_clk);
    warm_reset();
    expect_hex("update_shadow_count", 32'(n_upd), 32'(n_upd0 + 1));
    expect_true(t_upd > t_dis, "update_shadow did not follow dis_clk");
    pat = 8'($urandom_range(255, 0));
    release_with_word(pat);
    wait_wake_and_check_word(pat);

    repeat (5) @(negedge jbus_clk);
    $display("Finished with no errors");
    $finish;
  end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+logic
logic/rst_seq_pkg.sv
logic/rst_input_sync.sv
logic/bist_cfg_capture.sv
logic/rst_seq_fsm.sv
logic/rst_seq_outputs.sv
logic/rst_seq_top.sv
dv/rst_seq_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds the reset sequencer testbench with Verilator and runs it

set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f sources.f --top-module rst_seq_tb -Mdir obj_dir
status=$?
if [ $status -ne 0 ]; then
  echo "compile step failed with status $status"
  exit 1
fi

out=$(./obj_dir/Vrst_seq_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Finished with no errors" <<< "$out"; then
  exit 0
fi
exit 1
